/* logic/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and address widths
`define WORD_W 16
`define ADDR_W 16

`define REG_COUNT 32

// paging with one segment per page-table entry
`define PAGE_WORDS 64
`define SEG_COUNT 16
`define RAM_WORDS 1024

// first instruction and last fetchable address
`define PROGRAM_START 46
`define PROGRAM_LIMIT 62

`endif

/* logic/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [$clog2(`SEG_COUNT)-1:0] seg_t;
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

  typedef enum logic [7:0] {
    OP_JMP       = 8'd1,
    OP_JMP_PLUS  = 8'd5,
    OP_JMP_MINUS = 8'd7,
    OP_RAM2REG   = 8'd9,
    OP_NUM2REG   = 8'd18,
    OP_REG_PLUS  = 8'd19,
    OP_REG_MINUS = 8'd20,
    OP_REG_MUL   = 8'd21,
    OP_REG_DIV   = 8'd22
  } opcode_e;

  typedef enum logic [2:0] {
    ERR_NONE           = 3'd0,
    ERR_WRONG_ADDRESS  = 3'd1,
    ERR_DIVIDE_BY_ZERO = 3'd2,
    ERR_WRONG_REG_NUM  = 3'd3,
    ERR_WRONG_OPCODE   = 3'd4
  } error_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_MUL,
    ALU_DIV,
    ALU_SET
  } alu_op_e;

  // first word of every instruction
  typedef struct packed {
    opcode_e    opcode;
    logic [2:0] count_m1;  // registers in range minus one
    reg_idx_t   first_reg;
  } instr_t;

  typedef struct packed {
    alu_op_e  op;
    reg_idx_t first;
    reg_idx_t last;  // inclusive
    word_t    operand;
  } alu_req_t;

  typedef struct packed {
    seg_t       next;  // points to itself at the chain end
    logic [5:0] page;
    logic       used;
  } page_entry_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t data;
  } word_load_t;

  typedef struct packed {
    logic        we;
    seg_t        index;
    page_entry_t entry;
  } page_load_t;

endpackage

/* logic/word_ram.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module word_ram import cpu_pkg::*; #(
  parameter type payload_t = word_t,
  parameter int  DEPTH     = `RAM_WORDS
) (
  input  logic                              clk,
  input  logic [$bits(payload_t)+`ADDR_W:0] load,  // {we, addr, data}
  input  addr_t                             rd_addr,
  output payload_t                          rd_data
);

  localparam int IDX_W = $clog2(DEPTH);

  typedef struct packed {
    logic     we;
    addr_t    addr;
    payload_t data;
  } load_t;

  load_t    wr;
  payload_t mem [DEPTH];

  assign wr = load;

  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr[IDX_W-1:0]] <= wr.data;
    end
    rd_data <= mem[rd_addr[IDX_W-1:0]];  // one cycle read latency
  end

  a_wr_in_range: assert property (@(posedge clk) wr.we |-> wr.addr < DEPTH)
    else $error("write address %0d beyond depth %0d", wr.addr, DEPTH);

endmodule

/* logic/page_translator.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module page_translator import cpu_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       xlate_req,
  input  addr_t      xlate_addr,
  input  page_load_t page_load,
  output logic       xlate_done,
  output addr_t      xlate_paddr,
  output logic       xlate_fault
);

  localparam int OFS_W  = $clog2(`PAGE_WORDS);
  localparam int PAGE_W = `ADDR_W - OFS_W;

  typedef enum logic [1:0] {
    XL_IDLE,
    XL_HEAD,  // entry 0 on the table output
    XL_WALK   // entry cur_seg on the table output
  } xl_state_e;

  xl_state_e         state;
  logic [PAGE_W-1:0] page_q;
  logic [OFS_W-1:0]  offset_q;
  seg_t              cur_seg;
  addr_t             table_rd_addr;
  page_entry_t       entry;
  logic              hit;

  word_ram #(
    .payload_t(page_entry_t),
    .DEPTH    (`SEG_COUNT)
  ) page_table_i (
    .clk    (clk),
    .load   ({page_load.we, addr_t'(page_load.index), page_load.entry}),
    .rd_addr(table_rd_addr),
    .rd_data(entry)
  );

  // idle keeps the head entry on the output and later steps follow the chain
  assign table_rd_addr = (state == XL_IDLE) ? '0 : addr_t'(entry.next);
  assign hit = entry.used && (page_q == PAGE_W'(entry.page));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= XL_IDLE;
      page_q      <= '0;
      offset_q    <= '0;
      cur_seg     <= '0;
      xlate_done  <= 1'b0;
      xlate_fault <= 1'b0;
      xlate_paddr <= '0;
    end else begin
      xlate_done  <= 1'b0;
      xlate_fault <= 1'b0;
      case (state)
        XL_IDLE: begin
          if (xlate_req) begin
            page_q   <= xlate_addr[`ADDR_W-1:OFS_W];
            offset_q <= xlate_addr[OFS_W-1:0];
            if (xlate_addr[`ADDR_W-1:OFS_W] == '0) begin
              xlate_done  <= 1'b1;  // page 0 lives in segment 0
              xlate_paddr <= addr_t'(xlate_addr[OFS_W-1:0]);
            end else begin
              state <= XL_HEAD;
            end
          end
        end
        XL_HEAD: begin
          cur_seg <= entry.next;
          state   <= XL_WALK;
        end
        XL_WALK: begin
          if (hit) begin
            xlate_done  <= 1'b1;
            xlate_paddr <= addr_t'(cur_seg * `PAGE_WORDS + offset_q);
            state       <= XL_IDLE;
          end else if (entry.next == cur_seg) begin
            xlate_done  <= 1'b1;  // end of chain without a match
            xlate_fault <= 1'b1;
            state       <= XL_IDLE;
          end else begin
            cur_seg <= entry.next;
          end
        end
        default: state <= XL_IDLE;
      endcase
    end
  end

  a_no_req_in_walk: assert property (
    @(posedge clk) disable iff (!arst_n) xlate_req |-> state == XL_IDLE
  ) else $error("translation request during a chain walk");

endmodule

/* logic/reg_alu.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module reg_alu import cpu_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     alu_valid,
  input  alu_req_t alu_req,
  input  reg_idx_t reg_sel,
  output word_t    reg_value
);

  word_t regs [`REG_COUNT];

  // all results wrap to the word width
  function automatic word_t apply(alu_op_e op, word_t old, word_t arg);
    case (op)
      ALU_ADD: return old + arg;
      ALU_SUB: return old - arg;
      ALU_MUL: return old * arg;
      ALU_DIV: return old / arg;
      default: return arg;  // set and loads
    endcase
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (alu_valid) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        if (i >= alu_req.first && i <= alu_req.last) begin
          regs[i] <= apply(alu_req.op, regs[i], alu_req.operand);
        end
      end
    end
  end

  assign reg_value = regs[reg_sel];  // observation port

  // the sequencer range-checks before issuing
  a_range_order: assert property (
    @(posedge clk) disable iff (!arst_n) alu_valid |-> alu_req.first <= alu_req.last
  ) else $error("register range %0d..%0d reversed", alu_req.first, alu_req.last);

  a_div_nonzero: assert property (
    @(posedge clk) disable iff (!arst_n)
    alu_valid && alu_req.op == ALU_DIV |-> alu_req.operand != '0
  ) else $error("divide request with zero divisor");

endmodule

/* logic/instr_sequencer.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module instr_sequencer import cpu_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     run,
  input  logic     xlate_done,
  input  addr_t    xlate_paddr,
  input  logic     xlate_fault,
  input  word_t    rd_data,
  output logic     xlate_req,
  output addr_t    xlate_addr,
  output addr_t    rd_addr,
  output logic     alu_valid,
  output alu_req_t alu_req,
  output logic     halted,
  output error_e   error_code
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_FETCH,  // limit check and first-word request
    S_XL1,
    S_RD1,
    S_XL2,
    S_EXEC,
    S_LXL,    // translating a load source word
    S_LRD,
    S_HALT
  } seq_state_e;

  seq_state_e                   state;
  addr_t                        pc;  // address of the current instruction
  instr_t                       instr_q;
  addr_t                        load_addr;
  reg_idx_t                     load_reg;
  logic [$clog2(`REG_COUNT):0]  range_end;
  logic                         range_bad;
  logic [`ADDR_W:0]             back_pc;
  logic                         back_bad;

  function automatic alu_op_e alu_op_of(opcode_e op);
    case (op)
      OP_REG_PLUS:  return ALU_ADD;
      OP_REG_MINUS: return ALU_SUB;
      OP_REG_MUL:   return ALU_MUL;
      OP_REG_DIV:   return ALU_DIV;
      default:      return ALU_SET;
    endcase
  endfunction

  assign range_end = {1'b0, instr_q.first_reg} + instr_q.count_m1;
  assign range_bad = range_end >= `REG_COUNT;
  assign back_pc   = {1'b0, pc} - {rd_data, 1'b0};
  assign back_bad  = back_pc[`ADDR_W] || back_pc < `PROGRAM_START;  // borrow or below start

  // the translator holds its last physical address between requests
  assign rd_addr = xlate_paddr;
  assign halted  = (state == S_HALT);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= S_IDLE;
      pc         <= addr_t'(`PROGRAM_START);
      instr_q    <= '0;
      load_addr  <= '0;
      load_reg   <= '0;
      xlate_req  <= 1'b0;
      xlate_addr <= '0;
      alu_valid  <= 1'b0;
      alu_req    <= '0;
      error_code <= ERR_NONE;
    end else begin
      xlate_req <= 1'b0;
      alu_valid <= 1'b0;
      case (state)
        S_IDLE: if (run) state <= S_FETCH;
        S_FETCH: begin
          if (pc > `PROGRAM_LIMIT) begin
            state <= S_HALT;  // normal end of program
          end else begin
            xlate_req  <= 1'b1;
            xlate_addr <= pc;
            state      <= S_XL1;
          end
        end
        S_XL1, S_XL2, S_LXL: begin
          if (xlate_done && xlate_fault) begin
            error_code <= ERR_WRONG_ADDRESS;
            state      <= S_HALT;
          end else if (xlate_done) begin
            state <= (state == S_XL1) ? S_RD1 : (state == S_XL2) ? S_EXEC : S_LRD;
          end
        end
        S_RD1: begin
          instr_q    <= rd_data;
          xlate_req  <= 1'b1;
          xlate_addr <= pc + addr_t'(1);
          state      <= S_XL2;
        end
        S_EXEC: begin
          state <= S_FETCH;  // most opcodes go straight to the next fetch
          case (instr_q.opcode)
            OP_JMP: begin
              if (rd_data[0]) begin
                error_code <= ERR_WRONG_ADDRESS;
                state      <= S_HALT;
              end else begin
                pc <= rd_data;
              end
            end
            OP_JMP_PLUS: pc <= pc + {rd_data[`WORD_W-2:0], 1'b0};
            OP_JMP_MINUS: begin
              if (back_bad) begin
                error_code <= ERR_WRONG_ADDRESS;
                state      <= S_HALT;
              end else begin
                pc <= back_pc[`ADDR_W-1:0];
              end
            end
            OP_RAM2REG: begin
              if (range_bad) begin
                error_code <= ERR_WRONG_REG_NUM;
                state      <= S_HALT;
              end else begin
                load_addr  <= rd_data;
                load_reg   <= instr_q.first_reg;
                xlate_req  <= 1'b1;
                xlate_addr <= rd_data;
                state      <= S_LXL;
              end
            end
            OP_NUM2REG, OP_REG_PLUS, OP_REG_MINUS, OP_REG_MUL, OP_REG_DIV: begin
              if (range_bad) begin
                error_code <= ERR_WRONG_REG_NUM;
                state      <= S_HALT;
              end else if (instr_q.opcode == OP_REG_DIV && rd_data == '0) begin
                error_code <= ERR_DIVIDE_BY_ZERO;
                state      <= S_HALT;
              end else begin
                alu_valid       <= 1'b1;
                alu_req.op      <= alu_op_of(instr_q.opcode);
                alu_req.first   <= instr_q.first_reg;
                alu_req.last    <= range_end[$clog2(`REG_COUNT)-1:0];
                alu_req.operand <= rd_data;
                pc              <= pc + addr_t'(2);
              end
            end
            default: begin
              error_code <= ERR_WRONG_OPCODE;
              state      <= S_HALT;
            end
          endcase
        end
        S_LRD: begin
          alu_valid       <= 1'b1;  // single-register set
          alu_req.op      <= ALU_SET;
          alu_req.first   <= load_reg;
          alu_req.last    <= load_reg;
          alu_req.operand <= rd_data;
          if (load_reg == range_end[$clog2(`REG_COUNT)-1:0]) begin
            pc    <= pc + addr_t'(2);
            state <= S_FETCH;
          end else begin
            load_reg   <= load_reg + 1'b1;
            load_addr  <= load_addr + addr_t'(1);
            xlate_req  <= 1'b1;
            xlate_addr <= load_addr + addr_t'(1);
            state      <= S_LXL;
          end
        end
        default: state <= S_HALT;  // S_HALT holds until reset
      endcase
    end
  end

  // translator answers only while a request is outstanding
  a_done_expected: assert property (
    @(posedge clk) disable iff (!arst_n)
    xlate_done |-> state inside {S_XL1, S_XL2, S_LXL}
  ) else $error("unexpected translation done");

endmodule

/* logic/paged_cpu_top.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module paged_cpu_top import cpu_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  word_load_t prog_load,
  input  page_load_t page_load,
  input  logic       run,
  input  reg_idx_t   reg_sel,
  output word_t      reg_value,
  output logic       halted,
  output error_e     error_code
);

  logic     xlate_req;
  logic     xlate_done;
  logic     xlate_fault;
  addr_t    xlate_addr;
  addr_t    xlate_paddr;
  addr_t    rd_addr;
  word_t    rd_data;
  logic     alu_valid;
  alu_req_t alu_req;

  // program memory, loaded while run is low
  word_ram #(
    .payload_t(word_t),
    .DEPTH    (`RAM_WORDS)
  ) prog_ram_i (
    .clk    (clk),
    .load   (prog_load),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  page_translator page_translator_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .xlate_req  (xlate_req),
    .xlate_addr (xlate_addr),
    .page_load  (page_load),
    .xlate_done (xlate_done),
    .xlate_paddr(xlate_paddr),
    .xlate_fault(xlate_fault)
  );

  reg_alu reg_alu_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .alu_valid(alu_valid),
    .alu_req  (alu_req),
    .reg_sel  (reg_sel),
    .reg_value(reg_value)
  );

  instr_sequencer instr_sequencer_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .xlate_done (xlate_done),
    .xlate_paddr(xlate_paddr),
    .xlate_fault(xlate_fault),
    .rd_data    (rd_data),
    .xlate_req  (xlate_req),
    .xlate_addr (xlate_addr),
    .rd_addr    (rd_addr),
    .alu_valid  (alu_valid),
    .alu_req    (alu_req),
    .halted     (halted),
    .error_code (error_code)
  );

endmodule

/* dv/paged_cpu_tests.svh */
`ifndef PAGED_CPU_TESTS_SVH
`define PAGED_CPU_TESTS_SVH

// nine instructions that run off the fetch limit
task automatic test_arith();
  start_test("arithmetic");
  emit_alu(OP_NUM2REG, 2, 3, rand_word(16));
  emit_alu(OP_NUM2REG, 5, 4, rand_word(16));
  emit_alu(OP_REG_PLUS, 3, 4, rand_nonzero(16));
  emit_alu(OP_REG_MINUS, 2, 3, rand_nonzero(16));
  emit_alu(OP_REG_MUL, 4, 4, rand_nonzero(16));
  emit_alu(OP_REG_DIV, 2, 6, rand_nonzero(8));
  emit_alu(OP_REG_PLUS, 8, 1, rand_nonzero(16));
  emit_alu(OP_REG_MUL, 2, 2, rand_nonzero(16));
  emit_alu(OP_REG_MINUS, 6, 3, rand_nonzero(16));
  load_program();
  run_and_check(ERR_NONE);
endtask

task automatic test_jumps();
  start_test("jumps");
  emit_alu(OP_NUM2REG, 1, 1, rand_word(16));  // 46
  emit(OP_JMP_PLUS, 0, 1, 16'd2);             // 48 to 52
  emit(OP_NUM2REG, 2, 1, 16'hDEAD);           // skipped
  emit(OP_JMP, 0, 1, 16'd58);                 // 52
  emit_alu(OP_NUM2REG, 3, 1, rand_word(16));  // 54 is reached from 60
  emit(OP_JMP, 0, 1, 16'd64);                 // 56 ends the run
  emit_alu(OP_NUM2REG, 4, 1, rand_word(16));  // 58
  emit(OP_JMP_MINUS, 0, 1, 16'd3);            // 60 back to 54
  emit(OP_NUM2REG, 5, 1, 16'hBEEF);           // skipped
  load_program();
  run_and_check(ERR_NONE);
endtask

// chain 0 -> 3 -> 7 -> 9 with page 5 at the last entry
task automatic test_paged_load();
  start_test("paged load");
  set_entry(0, 3, 0, 1'b0);
  set_entry(3, 7, 2, 1'b1);
  set_entry(7, 9, 12, 1'b1);
  set_entry(9, 9, 5, 1'b1);
  stage_load(0, 3, 10, 0);
  stage_load(8, 4, 2 * `PAGE_WORDS + 20, 3);
  stage_load(16, 3, 5 * `PAGE_WORDS + 5, 9);
  load_program();
  run_and_check(ERR_NONE);
endtask

task automatic test_unmapped_page();
  start_test("unmapped page");
  set_entry(0, 3, 0, 1'b0);
  set_entry(3, 3, 2, 1'b1);
  emit_alu(OP_NUM2REG, 6, 2, rand_word(16));
  emit(OP_RAM2REG, 10, 2, word_t'(4 * `PAGE_WORDS + 3));  // page 4 not in chain
  load_program();
  run_and_check(ERR_WRONG_ADDRESS);
endtask

task automatic test_div_zero();
  start_test("divide by zero");
  emit_alu(OP_NUM2REG, 1, 3, rand_word(16));
  emit(OP_REG_DIV, 1, 3, 16'd0);
  load_program();
  run_and_check(ERR_DIVIDE_BY_ZERO);
endtask

task automatic test_reg_range();
  start_test("register range");
  emit_alu(OP_NUM2REG, 29, 3, rand_word(16));
  emit(OP_REG_PLUS, 30, 3, rand_nonzero(16));  // 30 to 32
  load_program();
  run_and_check(ERR_WRONG_REG_NUM);
endtask

task automatic test_odd_jump();
  start_test("odd jump target");
  emit_alu(OP_NUM2REG, 12, 1, rand_word(16));
  emit(OP_JMP, 0, 1, 16'd51);
  emit(OP_NUM2REG, 12, 1, 16'h1111);
  load_program();
  run_and_check(ERR_WRONG_ADDRESS);
endtask

task automatic test_jump_below_start();
  start_test("jump below start");
  emit_alu(OP_NUM2REG, 20, 2, rand_word(16));
  emit(OP_JMP_MINUS, 0, 1, 16'd2);  // 48 back to 44
  load_program();
  run_and_check(ERR_WRONG_ADDRESS);
endtask

task automatic test_bad_opcode();
  start_test("unknown opcode");
  emit_alu(OP_NUM2REG, 0, 8, rand_word(16));
  emit(8'd3, 0, 1, 16'h00FF);
  load_program();
  run_and_check(ERR_WRONG_OPCODE);
endtask

`endif

/* dv/paged_cpu_tb.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module paged_cpu_tb import cpu_pkg::*; ();

  localparam int TEST_COUNT  = 9;
  localparam int TEST_CYCLES = 2000;
  localparam int PROG_WORDS  = `PROGRAM_LIMIT + 2 - `PROGRAM_START;  // 9 instructions

  logic       clk;
  logic       arst_n;
  word_load_t prog_load;
  page_load_t page_load;
  logic       run;
  reg_idx_t   reg_sel;
  word_t      reg_value;
  logic       halted;
  error_e     error_code;

  logic [15:0] lfsr = 16'd59537;
  word_t       prog [$];
  word_t       model_regs [`REG_COUNT];  // expected register file

  paged_cpu_top paged_cpu_top_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .prog_load (prog_load),
    .page_load (page_load),
    .run       (run),
    .reg_sel   (reg_sel),
    .reg_value (reg_value),
    .halted    (halted),
    .error_code(error_code)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_error(string name, error_e got, error_e exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED at %0t: %s = %s (%0d), expected %s (%0d)",
                         $time, name, got.name(), got, exp.name(), exp));
    end
  endtask

  // 16-bit galois lfsr stepped once per bit
  function automatic logic lfsr_step();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 16'hB400;
    return out;
  endfunction

  function automatic word_t rand_word(int bits);
    word_t r;
    r = '0;
    for (int i = 0; i < bits; i++) begin
      r = {r[`WORD_W-2:0], lfsr_step()};
    end
    return r;
  endfunction

  function automatic word_t rand_nonzero(int bits);
    word_t r;
    r = rand_word(bits);
    while (r == '0) r = rand_word(bits);
    return r;
  endfunction

  // odd multiplier keeps every address bit in the value
  function automatic word_t fill_value(addr_t a);
    return word_t'(a * 16'h9E37) ^ 16'h3C5A;
  endfunction

  function automatic word_t instr_word(logic [7:0] op, int first, int count_m1);
    instr_t iw;
    iw.opcode    = opcode_e'(op);
    iw.count_m1  = count_m1[2:0];
    iw.first_reg = reg_idx_t'(first);
    return word_t'(iw);
  endfunction

  task automatic reset_dut();
    @(posedge clk);
    arst_n <= 1'b0;
    run    <= 1'b0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    prog.delete();
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
  endtask

  task automatic write_word(addr_t addr, word_t data);
    @(posedge clk);
    prog_load <= '{we: 1'b1, addr: addr, data: data};
    @(posedge clk);
    prog_load <= '0;
  endtask

  task automatic set_entry(int idx, int next, int page, logic used);
    @(posedge clk);
    page_load <= '{we: 1'b1, index: seg_t'(idx),
                   entry: '{next: seg_t'(next), page: 6'(page), used: used}};
    @(posedge clk);
    page_load <= '0;
  endtask

  // every entry ends its own chain and none is used
  task automatic load_pages();
    for (int i = 0; i < `SEG_COUNT; i++) begin
      set_entry(i, i, 0, 1'b0);
    end
  endtask

  task automatic emit(logic [7:0] op, int first, int count, word_t arg);
    prog.push_back(instr_word(op, first, count - 1));
    prog.push_back(arg);
  endtask

  // instruction that runs and so updates the model
  task automatic emit_alu(opcode_e op, int first, int count, word_t arg);
    emit(op, first, count, arg);
    for (int i = first; i < first + count; i++) begin
      case (op)
        OP_NUM2REG:   model_regs[i] = arg;
        OP_REG_PLUS:  model_regs[i] = model_regs[i] + arg;
        OP_REG_MINUS: model_regs[i] = model_regs[i] - arg;
        OP_REG_MUL:   model_regs[i] = model_regs[i] * arg;
        default:      model_regs[i] = model_regs[i] / arg;
      endcase
    end
  endtask

  // source words go to seg * page size + offset
  task automatic stage_load(int first, int count, int logical, int seg);
    addr_t phys;
    for (int i = 0; i < count; i++) begin
      phys = addr_t'(seg * `PAGE_WORDS + (logical + i) % `PAGE_WORDS);
      write_word(phys, fill_value(phys));
      model_regs[first + i] = fill_value(phys);
    end
    emit(OP_RAM2REG, first, count, word_t'(logical));
  endtask

  task automatic load_program();
    if (prog.size() > PROG_WORDS) begin
      fail_now("program does not fit below the fetch limit");
    end
    while (prog.size() < PROG_WORDS) begin
      prog.push_back(instr_word(OP_JMP, 0, 0));  // jump past the limit
      prog.push_back(word_t'(`PROGRAM_LIMIT + 2));
    end
    foreach (prog[i]) begin
      write_word(addr_t'(`PROGRAM_START + i), prog[i]);
    end
  endtask

  task automatic start_test(string name);
    $display("running test %s", name);
    reset_dut();
    load_pages();
  endtask

  task automatic run_and_check(error_e exp);
    @(posedge clk);
    run <= 1'b1;
    @(negedge clk);
    while (!halted) @(negedge clk);
    check_error("error_code", error_code, exp);
    for (int i = 0; i < `REG_COUNT; i++) begin
      @(posedge clk);
      reg_sel <= reg_idx_t'(i);
      @(negedge clk);
      check_word($sformatf("reg_value[r%0d]", i), reg_value, model_regs[i]);
    end
    if (!halted) begin
      fail_now("halted fell again while the registers were read");
    end
  endtask

  `include "paged_cpu_tests.svh"

  initial begin
    arst_n    = 1'b0;
    run       = 1'b0;
    prog_load = '0;
    page_load = '0;
    reg_sel   = '0;
    test_arith();
    test_jumps();
    test_paged_load();
    test_unmapped_page();
    test_div_zero();
    test_reg_range();
    test_odd_jump();
    test_jump_below_start();
    test_bad_opcode();
    $display("All tests passed");
    $finish;
  end

  initial begin
    repeat (TEST_COUNT * TEST_CYCLES) @(posedge clk);
    fail_now($sformatf("watchdog expired after %0d cycles", TEST_COUNT * TEST_CYCLES));
  end

endmodule

/* sources.f */
+incdir+logic
+incdir+dv
logic/cpu_pkg.sv
logic/word_ram.sv
logic/page_translator.sv
logic/reg_alu.sv
logic/instr_sequencer.sv
logic/paged_cpu_top.sv
dv/paged_cpu_tb.sv
